/* source/cpu_control_config.svh */
// Width macros for the data bus, FSM state, address mode and control words
`ifndef CPU_CONTROL_CONFIG_SVH
`define CPU_CONTROL_CONFIG_SVH

`define CPU_DB_W      8   // Opcode and data byte
`define CPU_STATE_W   6   // Room for the 28 FSM states
`define CPU_MODE_W    4   // Address mode code
`define CPU_AB_OP_W   12  // PC/AHL/ABH control plus ABL select, operand and carry
`define CPU_REG_OP_W  7   // Write bit, destination, source
`define CPU_ALU_OP_W  9   // Load-M, BCD, shift, add, carry

`endif

/* source/cpu_state_pkg.sv */
// FSM state enumeration and address mode codes
`include "cpu_control_config.svh"

package cpu_state_pkg;

    typedef enum logic [`CPU_STATE_W-1:0] {
        INIT, SYNC, IMM0, IND0, IND1, IND2, DATA, ABS0, ABS1, ZERO,
        PULL, RDWR, RTS0, RTS1, RTS2, PUSH, JSR0, JSR1, JSR2,
        BRK0, BRK1, BRK2, BRK3, RTI0, RTI1, RTI2, RTI3, COND
    } cpu_state_t;

    // Low two bits feed the ABL mux, bit 2 the ABL carry
    typedef enum logic [`CPU_MODE_W-1:0] {
        AM_HOLD      = 0,   // AB kept, AHL loads DB
        AM_PC        = 1,   // AB from PC
        AM_ABS_IDX   = 2,   // {DB, AHL + reg}, PC stored
        AM_ZP_IDX    = 3,   // {00, DB + reg}
        AM_NEXT      = 4,   // AB + 1, PC stored
        AM_PULL      = 5,   // {01, SP + 1}
        AM_BRANCH    = 7,   // AB + offset + 1
        AM_SP_KEEP   = 8,   // {01, SP}, PC kept
        AM_SP_SAVE   = 9,   // {01, SP}, PC stored plus one
        AM_ABS_KEEP  = 10,  // {DB, AHL + reg}, PC kept
        AM_SP_STORE  = 11,  // {01, SP}, AHL kept
        AM_NEXT_KEEP = 12,  // AB + 1, PC kept
        AM_ABS_INC   = 14,  // {DB, AHL + reg} + 1
        AM_VECTOR    = 15   // {FF, vector} + 1
    } ab_mode_t;

endpackage

/* source/cpu_ops_pkg.sv */
// Instruction field, control word structs and register and ALU codes
`include "cpu_control_config.svh"

package cpu_ops_pkg;

    typedef struct packed {
        logic [1:0]                shift;  // 10 left, 11 right
        logic [`CPU_ALU_OP_W-7:0]  add;    // OR AND XOR ADD INC DEC SUB TRB
        logic [1:0]                carry;  // 01 set, 10 rotate, 11 ADC
    } alu_sel_t;

    typedef struct packed {
        logic      ldm;  // Load M
        logic      bcd;
        alu_sel_t  sel;
    } alu_op_t;

    typedef struct packed {
        logic                      wr;   // Register write
        logic [1:0]                dst;
        logic [`CPU_REG_OP_W-4:0]  src;
    } reg_op_t;

    typedef struct packed {
        logic [`CPU_AB_OP_W-6:0] pc_ctl;   // PC, AHL and ABH control
        logic [1:0]              abl_sel;
        logic [1:0]              abl_op;
        logic                    abl_ci;
    } ab_op_t;

    typedef struct packed {
        logic        rmw;    // Hold address for write back
        logic        jmp;    // Absolute address goes to PC
        logic        ind;    // One more indirection pass
        logic        add_x;
        logic        add_y;
        logic        ld;     // Register load at end of instruction
        logic        st;
        logic [1:0]  dst;
        logic [3:0]  src;
        alu_sel_t    alu;
    } instr_fields_t;

    localparam logic [3:0] REG_X   = 4'd0;
    localparam logic [3:0] REG_Y   = 4'd1;
    localparam logic [3:0] REG_A   = 4'd2;
    localparam logic [3:0] REG_S   = 4'd3;
    localparam logic [3:0] REG_M   = 4'd5;
    localparam logic [3:0] REG_Z   = 4'd7;   // Reads as zero
    localparam logic [3:0] REG_VEC = 4'd10;  // BRK vector

    localparam alu_sel_t ALU_ORA    = 7'b00_000_00;
    localparam alu_sel_t ALU_AND    = 7'b00_001_00;
    localparam alu_sel_t ALU_EOR    = 7'b00_010_00;
    localparam alu_sel_t ALU_ADC    = 7'b00_011_11;
    localparam alu_sel_t ALU_PASS   = 7'b00_011_00;  // Add zero
    localparam alu_sel_t ALU_CMP    = 7'b00_101_01;
    localparam alu_sel_t ALU_SBC    = 7'b00_110_11;
    localparam alu_sel_t ALU_INC    = 7'b00_100_01;
    localparam alu_sel_t ALU_DEC    = 7'b00_101_00;
    localparam alu_sel_t ALU_STORE  = 7'b00_100_00;
    localparam alu_sel_t ALU_UNUSED = 7'b11_111_11;  // Opcode never loads

endpackage

/* source/opcode_decoder.sv */
// Opcode byte decode into instruction fields and the state after SYNC
`timescale 1ns/1ps
`include "cpu_control_config.svh"

module opcode_decoder (
    input  logic [`CPU_DB_W-1:0]       db,
    output cpu_ops_pkg::instr_fields_t decode,
    output cpu_state_pkg::cpu_state_t  entry
);
    import cpu_ops_pkg::*;
    import cpu_state_pkg::*;

    always_comb begin
        casez (db)
            8'h06, 8'hE6, 8'hEE: decode.rmw = 1'b1;  // ASL, INC
            default:             decode.rmw = 1'b0;
        endcase

        casez (db)
            8'h00, 8'h20, 8'h40, 8'h4C, 8'h60, 8'h6C, 8'h7C: decode.jmp = 1'b1;
            default:                                         decode.jmp = 1'b0;
        endcase

        casez (db)
            8'h6C, 8'h7C: decode.ind = 1'b1;  // JMP (IND), JMP (IND,X)
            default:      decode.ind = 1'b0;
        endcase

        casez (db)
            8'h7C, 8'hA1, 8'hB5, 8'hBD: decode.add_x = 1'b1;
            default:                    decode.add_x = 1'b0;
        endcase

        casez (db)
            8'hB1, 8'hB6, 8'hB9: decode.add_y = 1'b1;
            default:             decode.add_y = 1'b0;
        endcase

        casez (db)
            8'h48:   decode.st = 1'b1;  // PHA
            default: decode.st = 1'b0;
        endcase

        casez (db)
            8'hA0, 8'hA2, 8'hB6, 8'hCA, 8'hE8, 8'h68: decode.ld = 1'b1;
            8'b0???_??01, 8'b0???_0010,                     // ORA AND EOR ADC
            8'b101?_??01, 8'b101?_0010,                     // LDA
            8'b111?_??01, 8'b111?_0010: decode.ld = 1'b1;   // SBC, CMP excluded
            default:                    decode.ld = 1'b0;
        endcase

        casez (db)
            8'hA1, 8'hA5, 8'hA9, 8'hAD, 8'hB1, 8'hB2, 8'hB5, 8'hB9, 8'hBD,
            8'hA0, 8'hA2, 8'hB6, 8'h68: decode.src = REG_Z;  // Loads pass M
            8'hCA, 8'hE8:               decode.src = REG_X;  // DEX, INX
            8'h48:                      decode.src = REG_A;  // PHA
            8'hE6, 8'hEE:               decode.src = REG_M;  // INC memory
            8'b0???_??01, 8'b0???_0010: decode.src = REG_A;
            8'b101?_??01, 8'b101?_0010: decode.src = REG_Z;
            8'b11??_??01, 8'b11??_0010: decode.src = REG_A;  // CMP, SBC
            default:                    decode.src = 4'd0;
        endcase

        casez (db)
            8'h68:                      decode.dst = REG_A[1:0];
            8'hA2, 8'hB6, 8'hCA, 8'hE8: decode.dst = REG_X[1:0];
            8'hA0:                      decode.dst = REG_Y[1:0];
            8'b????_??01, 8'b????_0010: decode.dst = REG_A[1:0];  // Accumulator columns
            default:                    decode.dst = 2'd0;
        endcase

        casez (db)
            8'hA2, 8'hB6, 8'hA0, 8'hE6, 8'hEE, 8'h48, 8'h68: decode.alu = ALU_PASS;
            8'hCA:                      decode.alu = ALU_DEC;
            8'hE8:                      decode.alu = ALU_INC;
            8'b000?_??01, 8'b000?_0010: decode.alu = ALU_ORA;
            8'b001?_??01, 8'b001?_0010: decode.alu = ALU_AND;
            8'b010?_??01, 8'b010?_0010: decode.alu = ALU_EOR;
            8'b011?_??01, 8'b011?_0010: decode.alu = ALU_ADC;
            8'b101?_??01, 8'b101?_0010: decode.alu = ALU_PASS;  // LDA
            8'b110?_??01, 8'b110?_0010: decode.alu = ALU_CMP;
            8'b111?_??01, 8'b111?_0010: decode.alu = ALU_SBC;
            default:                    decode.alu = ALU_UNUSED;
        endcase

        casez (db)
            8'h80:   entry = COND;   // BRA
            8'h00:   entry = BRK0;
            8'h20:   entry = JSR0;
            8'h40:   entry = RTI0;
            8'h60:   entry = RTS0;
            8'h48:   entry = PUSH;
            8'h68:   entry = PULL;
            8'b????_0001, 8'b???1_0010:               entry = IND0;  // (ZP,X) (ZP),Y (ZP)
            8'b1010_00?0, 8'b11?0_00?0, 8'b???0_1001: entry = IMM0;  // Immediate forms
            8'b???1_1001, 8'b????_11??:               entry = ABS0;  // Absolute columns
            8'b????_01??:                             entry = ZERO;  // Zero page columns
            default: entry = SYNC;   // Unmatched opcode
        endcase
    end

endmodule

/* source/instr_sequencer.sv */
// Instruction FSM with state register and latched instruction fields
`timescale 1ns/1ps

module instr_sequencer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cpu_ops_pkg::instr_fields_t decode,
    input  cpu_state_pkg::cpu_state_t  entry,
    output cpu_state_pkg::cpu_state_t  state,
    output cpu_ops_pkg::instr_fields_t fields,
    output logic                       sync
);
    import cpu_state_pkg::*;

    cpu_state_t state_nxt;

    assign sync = (state == SYNC);  // Opcode fetch cycle

    always_comb begin
        case (state)
            INIT:    state_nxt = SYNC;
            SYNC:    state_nxt = entry;  // From opcode on db
            IMM0:    state_nxt = SYNC;
            IND0:    state_nxt = IND1;
            IND1:    state_nxt = IND2;
            IND2:    state_nxt = DATA;
            ABS0:    state_nxt = ABS1;
            ZERO:    state_nxt = fields.rmw ? RDWR : DATA;
            ABS1: begin
                if (fields.ind)                // Another pointer pass
                    state_nxt = ABS0;
                else if (fields.jmp)
                    state_nxt = SYNC;
                else if (fields.rmw)
                    state_nxt = RDWR;
                else
                    state_nxt = DATA;
            end
            RDWR:    state_nxt = DATA;
            DATA:    state_nxt = SYNC;
            PULL:    state_nxt = DATA;
            PUSH:    state_nxt = DATA;
            RTS0:    state_nxt = RTS1;
            RTS1:    state_nxt = RTS2;
            RTS2:    state_nxt = SYNC;
            JSR0:    state_nxt = JSR1;
            JSR1:    state_nxt = JSR2;
            JSR2:    state_nxt = ABS1;   // Target fetched via ABS1
            BRK0:    state_nxt = BRK1;
            BRK1:    state_nxt = BRK2;
            BRK2:    state_nxt = BRK3;
            BRK3:    state_nxt = ABS0;   // Vector read
            RTI0:    state_nxt = RTI1;
            RTI1:    state_nxt = RTI2;
            RTI2:    state_nxt = RTI3;
            RTI3:    state_nxt = SYNC;
            COND:    state_nxt = SYNC;
            default: state_nxt = INIT;   // Unused encodings
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            state <= INIT;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fields <= '0;
        end else if (sync) begin
            fields <= decode;            // Opcode sampled at end of SYNC
        end else if (state == ABS1) begin
            // Indirection done once, so JMP (IND) leaves the ABS0 loop
            fields.ind   <= 1'b0;
            fields.add_x <= 1'b0;
        end
    end

endmodule

/* source/address_op_encoder.sv */
// Per-state address mode and its expansion into the address operation word
`timescale 1ns/1ps
`include "cpu_control_config.svh"

module address_op_encoder (
    input  cpu_state_pkg::cpu_state_t state,
    input  logic                      cond,
    input  logic [`CPU_DB_W-1:0]      db,
    output cpu_ops_pkg::ab_op_t       ab_op
);
    import cpu_state_pkg::*;

    ab_mode_t                mode;
    logic                    back;      // Taken backward branch
    logic [`CPU_AB_OP_W-6:0] pc_code;
    logic [1:0]              abl_code;

    assign back = cond & db[7];

    always_comb begin
        case (state)
            INIT, RDWR:                         mode = AM_HOLD;
            DATA, JSR2:                         mode = AM_PC;
            ABS1, RTI3:                         mode = AM_ABS_IDX;
            IND0, ZERO:                         mode = AM_ZP_IDX;
            SYNC, ABS0, IMM0:                   mode = AM_NEXT;
            PULL, RTS0, RTS1, RTI0, RTI1, RTI2: mode = AM_PULL;
            COND:                               mode = AM_BRANCH;
            JSR1, BRK1, BRK2:                   mode = AM_SP_KEEP;
            JSR0, BRK0:                         mode = AM_SP_SAVE;
            IND2:                               mode = AM_ABS_KEEP;
            PUSH:                               mode = AM_SP_STORE;
            IND1:                               mode = AM_NEXT_KEEP;
            RTS2:                               mode = AM_ABS_INC;
            BRK3:                               mode = AM_VECTOR;
            default:                            mode = AM_HOLD;
        endcase
    end

    always_comb begin
        case (mode)
            AM_HOLD:      begin pc_code = 7'b001_0110; abl_code = 2'b11; end
            AM_PC:        begin pc_code = 7'b000_1010; abl_code = 2'b10; end
            AM_ABS_IDX:   begin pc_code = 7'b111_1110; abl_code = 2'b01; end
            AM_ZP_IDX:    begin pc_code = 7'b111_0000; abl_code = 2'b01; end
            AM_NEXT:      begin pc_code = 7'b011_0110; abl_code = 2'b11; end
            AM_PULL:      begin pc_code = 7'b011_0001; abl_code = 2'b00; end
            AM_BRANCH: begin
                pc_code  = back ? 7'b011_0111 : 7'b011_0110;  // ABH gets FF offset
                abl_code = 2'b11;
            end
            AM_SP_KEEP:   begin pc_code = 7'b000_0001; abl_code = 2'b00; end
            AM_SP_SAVE:   begin pc_code = 7'b111_0001; abl_code = 2'b00; end
            AM_ABS_KEEP:  begin pc_code = 7'b001_1110; abl_code = 2'b01; end
            AM_SP_STORE:  begin pc_code = 7'b010_0001; abl_code = 2'b00; end
            AM_NEXT_KEEP: begin pc_code = 7'b001_0110; abl_code = 2'b11; end
            AM_ABS_INC:   begin pc_code = 7'b001_1110; abl_code = 2'b01; end
            AM_VECTOR:    begin pc_code = 7'b000_0011; abl_code = 2'b00; end
            default:      begin pc_code = '0;          abl_code = 2'b00; end
        endcase
    end

    // ABL select and carry come straight from the mode bits
    assign ab_op = '{pc_ctl: pc_code, abl_sel: mode[1:0], abl_op: abl_code, abl_ci: mode[2]};

endmodule

/* source/datapath_op_encoder.sv */
// Register, ALU and data output select words plus the registered write enable
`timescale 1ns/1ps

module datapath_op_encoder (
    input  logic                       clk,
    input  logic                       rst_n,
    input  cpu_state_pkg::cpu_state_t  state,
    input  cpu_ops_pkg::instr_fields_t fields,
    output cpu_ops_pkg::reg_op_t       reg_op,
    output cpu_ops_pkg::alu_op_t       alu_op,
    output logic [1:0]                 do_op,
    output logic                       we
);
    import cpu_state_pkg::*;
    import cpu_ops_pkg::*;

    always_comb begin
        case (state)
            BRK0, BRK1, BRK2, JSR0, JSR1, RTS0, RTS1,
            RTI0, RTI1, RTI2, PUSH, PULL:
                reg_op = {1'b1, REG_S[1:0], REG_S};      // SP update
            BRK3: reg_op = {1'b0, 2'b00, REG_VEC};
            IND0: reg_op = {1'b0, 2'b00, fields.add_x ? REG_X : REG_Z};
            IND2: reg_op = {1'b0, 2'b00, fields.add_y ? REG_Y : REG_Z};
            ZERO, ABS1: begin
                if (fields.add_x)
                    reg_op = {1'b0, 2'b00, REG_X};
                else if (fields.add_y)
                    reg_op = {1'b0, 2'b00, REG_Y};
                else
                    reg_op = {1'b0, 2'b00, REG_Z};
            end
            SYNC:    reg_op = {fields.ld, fields.dst, fields.src};  // dst <= src op M
            DATA:    reg_op = {1'b0, fields.dst, fields.src};       // Store source
            default: reg_op = {1'b0, 2'b00, REG_Z};
        endcase
    end

    always_comb begin
        case (state)
            BRK0, BRK1, BRK2, JSR0, JSR1, PUSH:
                alu_op = {2'b00, ALU_DEC};   // SP - 1
            RTS0, RTS1, RTI0, RTI1, RTI2, PULL:
                alu_op = {2'b00, ALU_INC};   // SP + 1
            IMM0, RDWR: alu_op = {2'b10, ALU_ORA};       // Load M only
            SYNC:       alu_op = {2'b00, fields.alu};    // Finish previous op
            DATA: begin
                if (fields.st)
                    alu_op = {2'b00, ALU_STORE};
                else
                    alu_op = {2'b10, fields.alu};        // Load M or RMW
            end
            default:    alu_op = '0;
        endcase
    end

    // 00 ALU, 01 P, 10 PCL, 11 PCH
    always_comb begin
        case (state)
            BRK1, JSR1: do_op = 2'b11;
            BRK2, JSR2: do_op = 2'b10;
            BRK3:       do_op = 2'b01;
            default:    do_op = 2'b00;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            we <= 1'b0;
        else
            we <= state inside {BRK0, BRK1, BRK2, JSR0, JSR1, PUSH, RDWR};  // Bus write next cycle
    end

endmodule

/* source/cpu_control.sv */
// Control unit top with decoder, FSM and the address and datapath encoders
`timescale 1ns/1ps
`include "cpu_control_config.svh"

module cpu_control (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [`CPU_DB_W-1:0] db,
    input  logic                 cond,
    output logic                 sync,
    output logic                 we,
    output cpu_ops_pkg::ab_op_t  ab_op,
    output cpu_ops_pkg::reg_op_t reg_op,
    output cpu_ops_pkg::alu_op_t alu_op,
    output logic [1:0]           do_op
);
    import cpu_ops_pkg::*;
    import cpu_state_pkg::*;

    instr_fields_t decode;   // Combinational decode of db
    instr_fields_t fields;   // Latched at SYNC
    cpu_state_t    entry;
    cpu_state_t    state;

    opcode_decoder i_opcode_decoder (
        .db     (db),
        .decode (decode),
        .entry  (entry)
    );

    instr_sequencer i_instr_sequencer (
        .clk    (clk),
        .rst_n  (rst_n),
        .decode (decode),
        .entry  (entry),
        .state  (state),
        .fields (fields),
        .sync   (sync)
    );

    address_op_encoder i_address_op_encoder (
        .state (state),
        .cond  (cond),
        .db    (db),
        .ab_op (ab_op)
    );

    datapath_op_encoder i_datapath_op_encoder (
        .clk    (clk),
        .rst_n  (rst_n),
        .state  (state),
        .fields (fields),
        .reg_op (reg_op),
        .alu_op (alu_op),
        .do_op  (do_op),
        .we     (we)
    );

endmodule

/* test/tb_clock.sv */
// Free running testbench clock source
`timescale 1ns/1ps

module tb_clock #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;  // Half period per toggle

endmodule

/* test/tb_cpu_control.sv */
// Testbench for cpu_control with random opcodes, a sequence model and output checks
`timescale 1ns/1ps
`include "cpu_control_config.svh"

module tb_cpu_control;

    localparam int NUM_OPS    = 22;
    localparam int NUM_TRANS  = 300;
    localparam int SYNC_LIMIT = 20;

    // Opcodes drawn at SYNC, one or more per instruction class
    localparam logic [NUM_OPS*8-1:0] OP_LIST = {
        8'h09, 8'hA2, 8'hC9, 8'h80, 8'h05, 8'hB5, 8'h06, 8'h0D, 8'hB9, 8'hEE, 8'h4C,
        8'hB1, 8'hA1, 8'h6C, 8'h7C, 8'h48, 8'h68, 8'h60, 8'h40, 8'h20, 8'h00, 8'hE8
    };

    typedef enum logic [5:0] {
        S_INIT, S_SYNC, S_IMM0, S_IND0, S_IND1, S_IND2, S_DATA, S_ABS0, S_ABS1, S_ZERO,
        S_PULL, S_RDWR, S_RTS0, S_RTS1, S_RTS2, S_PUSH, S_JSR0, S_JSR1, S_JSR2,
        S_BRK0, S_BRK1, S_BRK2, S_BRK3, S_RTI0, S_RTI1, S_RTI2, S_RTI3, S_COND
    } st_t;

    typedef struct packed {
        logic       rmw;
        logic       jmp;
        logic       ind;
        logic       add_x;
        logic       add_y;
        logic       ld;
        logic       st;
        logic [1:0] dst;
        logic [3:0] src;
        logic [6:0] alu;
    } fields_t;

    logic                     clk;
    logic                     rst_n;
    logic [`CPU_DB_W-1:0]     db;
    logic                     cond;
    logic                     sync;
    logic                     we;
    logic [`CPU_AB_OP_W-1:0]  ab_op;
    logic [`CPU_REG_OP_W-1:0] reg_op;
    logic [`CPU_ALU_OP_W-1:0] alu_op;
    logic [1:0]               do_op;

    integer  seed;
    int      cycle_cnt;
    st_t     m_state;   // Model FSM
    fields_t m_fields;  // Model latched fields
    logic    m_we;

    tb_clock #(.PERIOD_NS(40)) i_tb_clock (.clk(clk));

    cpu_control i_cpu_control (
        .clk    (clk),
        .rst_n  (rst_n),
        .db     (db),
        .cond   (cond),
        .sync   (sync),
        .we     (we),
        .ab_op  (ab_op),
        .reg_op (reg_op),
        .alu_op (alu_op),
        .do_op  (do_op)
    );

    // {entry state, cycle count, rmw jmp ind x y ld st, dst, src, alu}
    function automatic logic [29:0] opcode_info(input logic [7:0] op);
        case (op)
            8'h09:   return {S_IMM0, 4'd2, 7'b0000010, 2'd2, 4'd2, 7'h00};  // ORA #
            8'hA2:   return {S_IMM0, 4'd2, 7'b0000010, 2'd0, 4'd7, 7'h0C};  // LDX #
            8'hC9:   return {S_IMM0, 4'd2, 7'b0000000, 2'd2, 4'd2, 7'h15};  // CMP #
            8'h80:   return {S_COND, 4'd2, 7'b0000000, 2'd0, 4'd0, 7'h7F};
            8'h05:   return {S_ZERO, 4'd3, 7'b0000010, 2'd2, 4'd2, 7'h00};
            8'hB5:   return {S_ZERO, 4'd3, 7'b0001010, 2'd2, 4'd7, 7'h0C};  // zp,X
            8'h06:   return {S_ZERO, 4'd4, 7'b1000000, 2'd0, 4'd0, 7'h7F};  // ASL zp
            8'h0D:   return {S_ABS0, 4'd4, 7'b0000010, 2'd2, 4'd2, 7'h00};
            8'hB9:   return {S_ABS0, 4'd4, 7'b0000110, 2'd2, 4'd7, 7'h0C};  // abs,Y
            8'hEE:   return {S_ABS0, 4'd5, 7'b1000000, 2'd0, 4'd5, 7'h0C};  // INC abs
            8'h4C:   return {S_ABS0, 4'd3, 7'b0100000, 2'd0, 4'd0, 7'h7F};
            8'hB1:   return {S_IND0, 4'd5, 7'b0000110, 2'd2, 4'd7, 7'h0C};  // (zp),Y
            8'hA1:   return {S_IND0, 4'd5, 7'b0001010, 2'd2, 4'd7, 7'h0C};  // (zp,X)
            8'h6C:   return {S_ABS0, 4'd5, 7'b0110000, 2'd0, 4'd0, 7'h7F};
            8'h7C:   return {S_ABS0, 4'd5, 7'b0111000, 2'd0, 4'd0, 7'h7F};
            8'h48:   return {S_PUSH, 4'd3, 7'b0000001, 2'd0, 4'd2, 7'h0C};
            8'h68:   return {S_PULL, 4'd3, 7'b0000010, 2'd2, 4'd7, 7'h0C};
            8'h60:   return {S_RTS0, 4'd4, 7'b0100000, 2'd0, 4'd0, 7'h7F};
            8'h40:   return {S_RTI0, 4'd5, 7'b0100000, 2'd0, 4'd0, 7'h7F};
            8'h20:   return {S_JSR0, 4'd5, 7'b0100000, 2'd0, 4'd0, 7'h7F};
            8'h00:   return {S_BRK0, 4'd7, 7'b0100000, 2'd0, 4'd0, 7'h7F};
            8'hE8:   return {S_SYNC, 4'd1, 7'b0000010, 2'd0, 4'd0, 7'h11};  // No entry state
            default: return {S_SYNC, 4'd1, 20'h0};
        endcase
    endfunction

    function automatic logic [11:0] expected_ab_op(input st_t s, input logic back);
        logic [3:0] mode;
        logic [8:0] pc_op;  // PC control and ABL operand
        case (s)
            S_INIT, S_RDWR:                               mode = 4'd0;
            S_DATA, S_JSR2:                               mode = 4'd1;
            S_ABS1, S_RTI3:                               mode = 4'd2;
            S_IND0, S_ZERO:                               mode = 4'd3;
            S_SYNC, S_ABS0, S_IMM0:                       mode = 4'd4;
            S_PULL, S_RTS0, S_RTS1, S_RTI0, S_RTI1, S_RTI2: mode = 4'd5;
            S_COND:                                       mode = 4'd7;
            S_JSR1, S_BRK1, S_BRK2:                       mode = 4'd8;
            S_JSR0, S_BRK0:                               mode = 4'd9;
            S_IND2:                                       mode = 4'd10;
            S_PUSH:                                       mode = 4'd11;
            S_IND1:                                       mode = 4'd12;
            S_RTS2:                                       mode = 4'd14;
            S_BRK3:                                       mode = 4'd15;
            default:                                      mode = 4'd0;
        endcase
        case (mode)
            4'd0:    pc_op = 9'b0010110_11;
            4'd1:    pc_op = 9'b0001010_10;
            4'd2:    pc_op = 9'b1111110_01;
            4'd3:    pc_op = 9'b1110000_01;
            4'd4:    pc_op = 9'b0110110_11;
            4'd5:    pc_op = 9'b0110001_00;
            4'd7:    pc_op = back ? 9'b0110111_11 : 9'b0110110_11;  // Backward branch
            4'd8:    pc_op = 9'b0000001_00;
            4'd9:    pc_op = 9'b1110001_00;
            4'd10:   pc_op = 9'b0011110_01;
            4'd11:   pc_op = 9'b0100001_00;
            4'd12:   pc_op = 9'b0010110_11;
            4'd14:   pc_op = 9'b0011110_01;
            4'd15:   pc_op = 9'b0000011_00;
            default: pc_op = 9'b0;
        endcase
        return {pc_op[8:2], mode[1:0], pc_op[1:0], mode[2]};
    endfunction

    // {write, dst, src}, Z source is 7
    function automatic logic [6:0] expected_reg_op(input st_t s, input fields_t f);
        case (s)
            S_BRK0, S_BRK1, S_BRK2, S_JSR0, S_JSR1, S_RTS0, S_RTS1,
            S_RTI0, S_RTI1, S_RTI2, S_PUSH, S_PULL:
                return 7'b1_11_0011;  // S from S
            S_BRK3:         return 7'b0_00_1010;
            S_IND0:         return f.add_x ? 7'h00 : 7'h07;
            S_IND2:         return f.add_y ? 7'h01 : 7'h07;
            S_ZERO, S_ABS1: return f.add_x ? 7'h00 : (f.add_y ? 7'h01 : 7'h07);
            S_SYNC:         return {f.ld, f.dst, f.src};
            S_DATA:         return {1'b0, f.dst, f.src};
            default:        return 7'h07;
        endcase
    endfunction

    function automatic logic [8:0] expected_alu_op(input st_t s, input fields_t f);
        case (s)
            S_BRK0, S_BRK1, S_BRK2, S_JSR0, S_JSR1, S_PUSH:   return {2'b00, 7'h14};  // Decrement
            S_RTS0, S_RTS1, S_RTI0, S_RTI1, S_RTI2, S_PULL:   return {2'b00, 7'h11};  // Increment
            S_IMM0, S_RDWR: return {2'b10, 7'h00};
            S_SYNC:         return {2'b00, f.alu};
            S_DATA:         return f.st ? {2'b00, 7'h10} : {2'b10, f.alu};
            default:        return 9'h0;
        endcase
    endfunction

    function automatic logic [1:0] expected_do_op(input st_t s);
        case (s)
            S_BRK1, S_JSR1: return 2'b11;  // PCH
            S_BRK2, S_JSR2: return 2'b10;  // PCL
            S_BRK3:         return 2'b01;  // P
            default:        return 2'b00;
        endcase
    endfunction

    task automatic abort_run;
        $display("SOME TESTS FAILED");
        $fatal(1, "Run stopped on first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Model update at the clock edge, from the inputs seen by the DUT
    task automatic advance_model;
        st_t         nxt;
        logic [29:0] info;
        if (!rst_n) begin
            m_state  = S_INIT;
            m_fields = '0;
            m_we     = 1'b0;
        end else begin
            m_we = m_state inside {S_BRK0, S_BRK1, S_BRK2, S_JSR0, S_JSR1, S_PUSH, S_RDWR};
            case (m_state)
                S_SYNC: begin
                    info     = opcode_info(db);
                    nxt      = st_t'(info[29:24]);
                    m_fields = info[19:0];
                end
                S_ZERO: nxt = m_fields.rmw ? S_RDWR : S_DATA;
                S_ABS1: begin
                    if (m_fields.ind)
                        nxt = S_ABS0;
                    else if (m_fields.jmp)
                        nxt = S_SYNC;
                    else if (m_fields.rmw)
                        nxt = S_RDWR;
                    else
                        nxt = S_DATA;
                    m_fields.ind   = 1'b0;
                    m_fields.add_x = 1'b0;
                end
                S_IND0:  nxt = S_IND1;
                S_IND1:  nxt = S_IND2;
                S_ABS0:  nxt = S_ABS1;
                S_RTS0:  nxt = S_RTS1;
                S_RTS1:  nxt = S_RTS2;
                S_JSR0:  nxt = S_JSR1;
                S_JSR1:  nxt = S_JSR2;
                S_JSR2:  nxt = S_ABS1;
                S_BRK0:  nxt = S_BRK1;
                S_BRK1:  nxt = S_BRK2;
                S_BRK2:  nxt = S_BRK3;
                S_BRK3:  nxt = S_ABS0;
                S_RTI0:  nxt = S_RTI1;
                S_RTI1:  nxt = S_RTI2;
                S_RTI2:  nxt = S_RTI3;
                S_IND2, S_PUSH, S_PULL, S_RDWR: nxt = S_DATA;
                default: nxt = S_SYNC;  // INIT, IMM0, DATA, COND, RTS2, RTI3
            endcase
            m_state = nxt;
        end
    endtask

    task automatic drive_inputs;
        logic [31:0] rnd;
        int          idx;
        rnd = $random(seed);
        idx = $unsigned($random(seed)) % NUM_OPS;
        if (m_state == S_SYNC)
            db <= OP_LIST[idx*8 +: 8];  // Opcode for the coming fetch cycle
        else
            db <= rnd[7:0];
        cond <= rnd[8];
    endtask

    task automatic check_outputs;
        check_value("sync", sync, m_state == S_SYNC);
        check_value("we", we, m_we);
        check_value("ab_op", ab_op, expected_ab_op(m_state, cond & db[7]));
        check_value("reg_op", reg_op, expected_reg_op(m_state, m_fields));
        check_value("alu_op", alu_op, expected_alu_op(m_state, m_fields));
        check_value("do_op", do_op, expected_do_op(m_state));
    endtask

    // Drive at the rising edge, check at the falling edge
    task automatic next_cycle;
        @(posedge clk);
        advance_model();
        drive_inputs();
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt == 3)
            rst_n <= 1'b1;
        @(negedge clk);
        check_outputs();
    endtask

    task automatic wait_for_sync(output int cycles);
        logic done;
        cycles = 0;
        done   = 1'b0;
        while (!done) begin
            next_cycle();
            cycles = cycles + 1;
            if (sync === 1'b1) begin
                done = 1'b1;
            end else if (cycles >= SYNC_LIMIT) begin
                $display("Timeout: sync did not return within %0d cycles", SYNC_LIMIT);
                abort_run();
            end
        end
    endtask

    initial begin
        int          n;
        logic [29:0] info;
        seed      = 32'hd327_c9a5;
        rst_n     = 1'b0;
        db        = '0;
        cond      = 1'b0;
        cycle_cnt = 0;
        m_state   = S_INIT;
        m_fields  = '0;
        m_we      = 1'b0;

        repeat (3) next_cycle();     // Reset low for three edges
        wait_for_sync(n);
        check_value("cycles from reset release to sync", n + 1, 2);

        repeat (NUM_TRANS) begin
            info = opcode_info(db);  // Opcode of this fetch cycle
            wait_for_sync(n);
            check_value("sync to sync cycles", n, info[23:20]);
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* compile.f */
+incdir+source
source/cpu_state_pkg.sv
source/cpu_ops_pkg.sv
source/opcode_decoder.sv
source/instr_sequencer.sv
source/address_op_encoder.sv
source/datapath_op_encoder.sv
source/cpu_control.sv
test/tb_clock.sv
test/tb_cpu_control.sv

/* Bender.yml */
package:
  name: cpu_control

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/cpu_state_pkg.sv
      - source/cpu_ops_pkg.sv
      - source/opcode_decoder.sv
      - source/instr_sequencer.sv
      - source/address_op_encoder.sv
      - source/datapath_op_encoder.sv
      - source/cpu_control.sv
  - target: test
    include_dirs:
      - source
    files:
      - test/tb_clock.sv
      - test/tb_cpu_control.sv
